// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module hisTb -Mdir obj_dir -o hisSim \
    && ./obj_dir/hisSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// ==== source/algebraicBlock.sv ====
module algebraicBlock #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   peakDone,
    input  logic [binBits-1:0]     peakBin,
    input  hisPkg::hisPhaseT       peakPhase,
    output logic [sampleWidth-1:0] thMinus,
    output logic [sampleWidth-1:0] thPositive,
    output logic [binBits-1:0]     peakCH,
    output logic [binBits-1:0]     peakFH,
    output logic [sampleWidth-1:0] peakValue,
    output logic                   resultValid
);

    localparam int coarseShift = sampleWidth - binBits;
    localparam int fineShift = sampleWidth - 2 * binBits;
    // w - 1 and delta / 2
    localparam logic [sampleWidth-1:0] winSpan = sampleWidth'((1 << coarseShift) - 1);
    localparam logic [sampleWidth-1:0] halfDelta = sampleWidth'((1 << fineShift) / 2);

    logic [sampleWidth-1:0] coarseBase;
    logic [sampleWidth-1:0] fineOffset;

    // peakCH * w
    assign coarseBase = sampleWidth'(peakBin) << coarseShift;
    // peakFH * delta
    assign fineOffset = sampleWidth'(peakBin) << fineShift;

    always_ff @(posedge clk) begin
        if (rst) begin
            thMinus <= '0;
            thPositive <= '0;
            peakCH <= '0;
            peakFH <= '0;
            peakValue <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (peakDone && (peakPhase == hisPkg::phaseCoarse)) begin
                // window for the following fine pass
                peakCH <= peakBin;
                thMinus <= coarseBase;
                thPositive <= coarseBase + winSpan;
            end else if (peakDone) begin
                // centre of the fine peak bin
                peakFH <= peakBin;
                peakValue <= thMinus + fineOffset + halfDelta;
                resultValid <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        thPositive >= thMinus);

endmodule

// ==== source/dataFolder.sv ====
module dataFolder #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4
) (
    input  logic [sampleWidth-1:0] roughData,
    input  hisPkg::hisPhaseT       hisNum,
    input  logic [sampleWidth-1:0] thMinus,
    output logic [binBits-1:0]     binAddr,
    output logic                   inWindow
);

    // coarse bin width is 2**coarseShift, fine bin width is 2**fineShift
    localparam int coarseShift = sampleWidth - binBits;
    localparam int fineShift = sampleWidth - 2 * binBits;
    // window spans one coarse bin
    localparam logic [sampleWidth-1:0] winSpan = sampleWidth'((1 << coarseShift) - 1);

    logic [sampleWidth-1:0] thUpper;
    logic [sampleWidth-1:0] offset;

    // upper window edge, inclusive
    assign thUpper = thMinus + winSpan;
    // distance from the lower edge
    // only meaningful when the sample is inside the window
    assign offset = roughData - thMinus;

    always_comb begin
        if (hisNum == hisPkg::phaseCoarse) begin
            // top bits select the coarse bin
            binAddr = roughData[sampleWidth-1 -: binBits];
            inWindow = 1'b1;
        end else begin
            // offset divided by delta
            binAddr = offset[fineShift +: binBits];
            inWindow = (roughData >= thMinus) && (roughData <= thUpper);
        end
    end

endmodule

// ==== source/hisBuilderFsm.sv ====
module hisBuilderFsm #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4,
    parameter int countWidth = 8,
    parameter int samplesPerHis = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wrEn,
    input  logic [binBits-1:0]    binAddr,
    input  logic                  inWindow,
    output logic                  acqReady,
    output hisPkg::hisPhaseT      hisNum,
    output logic                  binValid,
    output logic [binBits-1:0]    binIndex,
    output logic [countWidth-1:0] binCount
);

    localparam int numBins = 1 << binBits;
    localparam int cntBits = $clog2(samplesPerHis + 1);
    localparam logic [cntBits-1:0] lastSample = cntBits'(samplesPerHis - 1);

    // fine pass needs at least one sample value per fine bin
    if (sampleWidth < 2 * binBits) begin : gWidthCheck
        $error("sampleWidth too small for two passes of binBits");
    end

    hisPkg::builderStateT  state;
    logic [binBits-1:0]    binPtr;
    logic [cntBits-1:0]    sampleCnt;
    logic [countWidth-1:0] binMem [numBins];
    logic                  accept;
    logic                  incEn;

    // levels decoded straight from the state
    assign acqReady = (state == hisPkg::stAcquire);
    assign binValid = (state == hisPkg::stReadout);
    assign binIndex = binPtr;
    assign binCount = binMem[binPtr];

    // a strobe only counts while acquiring
    assign accept = acqReady && wrEn;
    // out-of-window samples still count toward samplesPerHis
    assign incEn = accept && inWindow;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hisPkg::stClear;
            binPtr <= '0;
            sampleCnt <= '0;
            hisNum <= hisPkg::phaseCoarse;
        end else begin
            case (state)
                hisPkg::stClear: begin
                    // one counter per cycle, pointer wraps back to 0
                    binPtr <= binPtr + 1'b1;
                    if (&binPtr) begin
                        state <= hisPkg::stAcquire;
                    end
                end
                hisPkg::stAcquire: begin
                    if (accept) begin
                        if (sampleCnt == lastSample) begin
                            sampleCnt <= '0;
                            state <= hisPkg::stReadout;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                hisPkg::stReadout: begin
                    binPtr <= binPtr + 1'b1;
                    // last bin out, switch pass
                    if (&binPtr) begin
                        state <= hisPkg::stClear;
                        hisNum <= (hisNum == hisPkg::phaseCoarse) ?
                                  hisPkg::phaseFine : hisPkg::phaseCoarse;
                    end
                end
                default: state <= hisPkg::stClear;
            endcase
        end
    end

    // counter array
    always_ff @(posedge clk) begin
        if (state == hisPkg::stClear) begin
            binMem[binPtr] <= '0;
        end else if (incEn && (binMem[binAddr] != '1)) begin
            // saturate at full scale
            binMem[binAddr] <= binMem[binAddr] + 1'b1;
        end
    end

    // readout and acquire never share a cycle, nor the one after readout
    assert property (@(posedge clk) disable iff (rst)
        binValid |-> !acqReady ##1 !acqReady);

    // counters hold still while they stream out
    assert property (@(posedge clk) disable iff (rst)
        binValid |=> binMem[$past(binPtr)] == $past(binCount));

endmodule

// ==== source/hisPkg.sv ====
package hisPkg;

    // pass in progress
    // coarse bins on the upper bits of the sample,
    // fine bins only inside the window found by the coarse pass
    typedef enum logic {
        phaseCoarse = 1'b0,
        phaseFine   = 1'b1
    } hisPhaseT;

    // builder sequencing
    // clear walks the counter array once,
    // acquire bins the accepted samples,
    // readout streams every counter out in index order
    typedef enum logic [1:0] {
        stClear   = 2'd0,
        stAcquire = 2'd1,
        stReadout = 2'd2
    } builderStateT;

    // 2'd3 is unused
    // the builder falls back to clear if it ever lands there

endpackage

// ==== source/hisTop.sv ====
module hisTop #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4,
    parameter int countWidth = 8,
    parameter int samplesPerHis = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wrEn,
    input  logic [sampleWidth-1:0] roughData,
    output logic                   acqReady,
    output logic [sampleWidth-1:0] thMinus,
    output logic [sampleWidth-1:0] thPositive,
    output logic [binBits-1:0]     peakCH,
    output logic [binBits-1:0]     peakFH,
    output logic [sampleWidth-1:0] peakValue,
    output logic                   resultValid
);

    // sample path
    logic [binBits-1:0]    binAddr;
    logic                  inWindow;
    hisPkg::hisPhaseT      hisNum;

    // readout stream
    logic                  binValid;
    logic [binBits-1:0]    binIndex;
    logic [countWidth-1:0] binCount;

    // peak result
    logic                  peakDone;
    logic [binBits-1:0]    peakBin;
    hisPkg::hisPhaseT      peakPhase;

    dataFolder #(
        .sampleWidth(sampleWidth),
        .binBits(binBits)
    ) uDataFolder (
        .roughData(roughData),
        .hisNum(hisNum),
        .thMinus(thMinus),
        .binAddr(binAddr),
        .inWindow(inWindow)
    );

    hisBuilderFsm #(
        .sampleWidth(sampleWidth),
        .binBits(binBits),
        .countWidth(countWidth),
        .samplesPerHis(samplesPerHis)
    ) uHisBuilderFsm (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .binAddr(binAddr),
        .inWindow(inWindow),
        .acqReady(acqReady),
        .hisNum(hisNum),
        .binValid(binValid),
        .binIndex(binIndex),
        .binCount(binCount)
    );

    peakDetector #(
        .binBits(binBits),
        .countWidth(countWidth)
    ) uPeakDetector (
        .clk(clk),
        .rst(rst),
        .hisNum(hisNum),
        .binValid(binValid),
        .binIndex(binIndex),
        .binCount(binCount),
        .peakDone(peakDone),
        .peakBin(peakBin),
        .peakPhase(peakPhase)
    );

    algebraicBlock #(
        .sampleWidth(sampleWidth),
        .binBits(binBits)
    ) uAlgebraicBlock (
        .clk(clk),
        .rst(rst),
        .peakDone(peakDone),
        .peakBin(peakBin),
        .peakPhase(peakPhase),
        .thMinus(thMinus),
        .thPositive(thPositive),
        .peakCH(peakCH),
        .peakFH(peakFH),
        .peakValue(peakValue),
        .resultValid(resultValid)
    );

endmodule

// ==== source/peakDetector.sv ====
module peakDetector #(
    parameter int binBits = 4,
    parameter int countWidth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  hisPkg::hisPhaseT      hisNum,
    input  logic                  binValid,
    input  logic [binBits-1:0]    binIndex,
    input  logic [countWidth-1:0] binCount,
    output logic                  peakDone,
    output logic [binBits-1:0]    peakBin,
    output hisPkg::hisPhaseT      peakPhase
);

    logic [countWidth-1:0] maxCount;
    logic [binBits-1:0]    maxIdx;
    logic                  lastBin;

    // final bin of the readout stream
    assign lastBin = binValid && (&binIndex);

    // running index is the result once the stream has ended
    assign peakBin = maxIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            maxCount <= '0;
            maxIdx <= '0;
            peakDone <= 1'b0;
            peakPhase <= hisPkg::phaseCoarse;
        end else begin
            // one cycle after the last bin
            peakDone <= lastBin;
            if (binValid) begin
                // hisNum flips on the edge after bin 15,
                // so sample it while the stream is running
                peakPhase <= hisNum;
                if (binIndex == '0) begin
                    // restart on the first bin
                    maxCount <= binCount;
                    maxIdx <= '0;
                end else if (binCount > maxCount) begin
                    // strictly larger only, lowest index wins ties
                    maxCount <= binCount;
                    maxIdx <= binIndex;
                end
            end
        end
    end

    // single-cycle pulse per pass
    assert property (@(posedge clk) disable iff (rst)
        peakDone |=> !peakDone);

endmodule

// ==== tb.f ====
source/hisPkg.sv
source/dataFolder.sv
source/hisBuilderFsm.sv
source/peakDetector.sv
source/algebraicBlock.sv
source/hisTop.sv
verif/hisTb.sv

// ==== verif/hisTb.sv ====
module hisTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sampleWidth = 10;
    localparam int binBits = 4;
    localparam int countWidth = 8;
    localparam int samplesPerHis = 64;
    localparam int numBins = 1 << binBits;
    // coarse bin width w and fine bin width delta
    localparam int coarseWidth = 1 << (sampleWidth - binBits);
    localparam int fineWidth = 1 << (sampleWidth - 2 * binBits);
    localparam int countMax = (1 << countWidth) - 1;
    localparam int maxSample = (1 << sampleWidth) - 1;
    localparam int numFrames = 8;
    localparam int tieFrame = 3;
    localparam int waitLimit = 2000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   wrEn;
    logic [sampleWidth-1:0] roughData;
    logic                   acqReady;
    logic [sampleWidth-1:0] thMinus;
    logic [sampleWidth-1:0] thPositive;
    logic [binBits-1:0]     peakCH;
    logic [binBits-1:0]     peakFH;
    logic [sampleWidth-1:0] peakValue;
    logic                   resultValid;

    // per-frame stimulus shape
    int centre;
    bit tieMode;

    // reference model
    int coarseHist[numBins];
    int fineHist[numBins];
    int modelCnt;
    bit modelFine;
    int modelThMinus;
    int expPeakCH;
    int expThPositive;
    int expPeakFH;
    int expPeakValue;
    int modelFrames;

    int errorCount = 0;
    int checkCount = 0;

    hisTop #(
        .sampleWidth(sampleWidth),
        .binBits(binBits),
        .countWidth(countWidth),
        .samplesPerHis(samplesPerHis)
    ) uut (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .roughData(roughData),
        .acqReady(acqReady),
        .thMinus(thMinus),
        .thPositive(thPositive),
        .peakCH(peakCH),
        .peakFH(peakFH),
        .peakValue(peakValue),
        .resultValid(resultValid)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic logic [sampleWidth-1:0] drawSample();
        int v;
        int k;
        // index of the next sample the DUT will accept
        k = modelCnt % numBins;
        if (tieMode) begin
            // sweep so every bin gets samplesPerHis / numBins hits in either pass
            v = modelFine ? modelThMinus + k * fineWidth : k * coarseWidth;
        end else if ($urandom_range(99) < 80) begin
            // cluster around the frame centre
            v = centre + int'($urandom_range(48)) - 24;
        end else begin
            v = int'($urandom_range(maxSample));
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > maxSample) begin
            v = maxSample;
        end
        return sampleWidth'(v);
    endfunction

    // lowest index wins a tie
    function automatic int findPeak(input int hist[numBins]);
        int best;
        logic [binBits-1:0] idx;
        best = 0;
        for (int i = 1; i < numBins; i++) begin
            idx = binBits'(i);
            if (hist[idx] > hist[binBits'(best)]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic modelAccept(input int d);
        logic [binBits-1:0] bin;
        if (!modelFine) begin
            bin = binBits'(d / coarseWidth);
            coarseHist[bin] = (coarseHist[bin] < countMax) ? coarseHist[bin] + 1 : countMax;
        end else if (d >= modelThMinus && d <= modelThMinus + coarseWidth - 1) begin
            // out of window still counts toward the pass, just not binned
            bin = binBits'((d - modelThMinus) / fineWidth);
            fineHist[bin] = (fineHist[bin] < countMax) ? fineHist[bin] + 1 : countMax;
        end
        modelCnt++;
        if (modelCnt == samplesPerHis) begin
            if (!modelFine) begin
                expPeakCH = findPeak(coarseHist);
                modelThMinus = expPeakCH * coarseWidth;
                expThPositive = modelThMinus + coarseWidth - 1;
            end else begin
                expPeakFH = findPeak(fineHist);
                expPeakValue = modelThMinus + expPeakFH * fineWidth + fineWidth / 2;
                modelFrames++;
            end
            coarseHist = '{default: 0};
            fineHist = '{default: 0};
            modelCnt = 0;
            modelFine = !modelFine;
        end
    endtask

    // drive on the rising edge, wrEn about 70% of cycles in every state
    always @(posedge clk) begin
        wrEn <= ($urandom_range(99) < 70);
        roughData <= drawSample();
    end

    // inputs and acqReady are stable at the falling edge,
    // so a strobe seen here is the one taken on the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            coarseHist = '{default: 0};
            fineHist = '{default: 0};
            modelCnt = 0;
            modelFine = 1'b0;
            modelThMinus = 0;
            modelFrames = 0;
        end else if (wrEn && acqReady) begin
            modelAccept(int'(roughData));
        end
    end

    task automatic idleOutputs(input string tag);
        checkValue({tag, " acqReady"}, 0, 32'(acqReady));
        checkValue({tag, " resultValid"}, 0, 32'(resultValid));
        checkValue({tag, " thMinus"}, 0, 32'(thMinus));
        checkValue({tag, " thPositive"}, 0, 32'(thPositive));
        checkValue({tag, " peakCH"}, 0, 32'(peakCH));
        checkValue({tag, " peakFH"}, 0, 32'(peakFH));
        checkValue({tag, " peakValue"}, 0, 32'(peakValue));
    endtask

    // poll a level at the falling edge, bounded
    task automatic waitHigh(input bit forResult, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < waitLimit) begin
            @(negedge clk);
            ok = forResult ? (resultValid === 1'b1) : (acqReady === 1'b1);
            cycles++;
        end
        if (!ok) begin
            errorCount++;
            $display("%s did not go high within %0d cycles",
                     forResult ? "resultValid" : "acqReady", waitLimit);
        end
    endtask

    task automatic checkFrame(input int frame);
        string tag;
        tag = $sformatf("frame %0d", frame);
        checkValue({tag, " passes done"}, frame + 1, modelFrames);
        checkValue({tag, " peakCH"}, expPeakCH, 32'(peakCH));
        checkValue({tag, " thMinus"}, modelThMinus, 32'(thMinus));
        checkValue({tag, " thPositive"}, expThPositive, 32'(thPositive));
        checkValue({tag, " peakFH"}, expPeakFH, 32'(peakFH));
        checkValue({tag, " peakValue"}, expPeakValue, 32'(peakValue));
        if (tieMode) begin
            // flat histograms resolve to bin 0
            checkValue({tag, " tie peakCH"}, 0, 32'(peakCH));
            checkValue({tag, " tie peakFH"}, 0, 32'(peakFH));
        end
    endtask

    initial begin
        bit ok;
        void'($urandom(18696));
        rst = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        tieMode = 1'b0;
        centre = 0;
        ok = 1'b1;
        // reset seen on 16 rising edges
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            idleOutputs("reset");
        end
        // first cycle out of reset is still in clear
        @(negedge clk);
        idleOutputs("after reset");
        for (int frame = 0; frame < numFrames && ok; frame++) begin
            // new shape before the coarse acquire starts
            tieMode = (frame == tieFrame);
            centre = int'($urandom_range(maxSample));
            waitHigh(1'b0, ok);
            if (ok) begin
                waitHigh(1'b1, ok);
            end
            if (ok) begin
                checkFrame(frame);
            end
        end
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
